// File: filelist.f
+incdir+verilog
verilog/qos_pkt_pkg.sv
verilog/qos_stat_pkg.sv
verilog/qos_if.sv
verilog/pkt_assembler.sv
verilog/queue_bank.sv
verilog/sched_cfg_regs.sv
verilog/read_scheduler.sv
verilog/stat_counters.sv
verilog/qos_buffer_top.sv
sim/qos_sva.sv
sim/qos_tb.sv

// File: sim/qos_sva.sv
`include "qos_config.svh"

module qos_sva (
	input  logic                    clk,
	input  logic                    arst_n_i,
	input  logic                    rd_credit_i,
	input  logic                    rd_valid_o,
	input  qos_pkt_pkg::occ_t       occ [`QOS_NUM_Q]
);
	timeunit 1ns;
	timeprecision 1ps;

	// credits returned minus reads seen on the ports
	logic [`QOS_CRED_W:0] balance;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			balance <= '0;
		end else begin
			balance <= balance + rd_credit_i - rd_valid_o;
		end
	end

	// each read needs a credit returned before its pop edge
	read_needs_credit: assert property (@(posedge clk) disable iff (!arst_n_i)
		rd_valid_o |-> $past(balance) > $past(rd_valid_o))
		else $error("read issued without an outstanding credit");

	for (genvar q = 0; q < `QOS_NUM_Q; q++) begin : g_occ
		occ_in_range: assert property (@(posedge clk) disable iff (!arst_n_i)
			occ[q] <= `QOS_DEPTH)
			else $error("queue %0d occupancy above depth", q);
	end

	read_low_after_reset: assert property (@(posedge clk)
		$rose(arst_n_i) |-> !rd_valid_o)
		else $error("read valid high right after reset");

endmodule

bind qos_buffer_top qos_sva u_qos_sva (
	.clk         (clk),
	.arst_n_i    (arst_n_i),
	.rd_credit_i (rd_credit_i),
	.rd_valid_o  (rd_valid_o),
	.occ         (u_qif.occ)
);

// File: sim/qos_tb.sv
`include "qos_config.svh"

module qos_tb;
	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [2:0] {SEND, CREDIT, THR, FILL, DRAIN} op_e;
	typedef struct packed {
		op_e op;
		int  q;
		int  val;
		int  exp_q;
		int  exp_d;
	} step_t;

	logic clk, arst_n_i, bit_valid_i, bit_i, rd_credit_i, cfg_we_i;
	logic [2:0] cfg_thr_i;
	logic [1:0] stat_qid_i, rd_qid_o, rd_data_o;
	logic [6:0] rx_count_o, rd_count_o, drop_count_o;
	logic rd_valid_o;

	// model queues with entry 0 the oldest
	int mq [`QOS_NUM_Q][`QOS_DEPTH];
	int mocc [`QOS_NUM_Q];
	int rx_cnt [`QOS_NUM_Q];
	int rd_cnt [`QOS_NUM_Q];
	int drop_cnt [`QOS_NUM_Q];
	int thr = 3;
	int errors = 0;
	int timeouts = 0;
	int unsigned seed = 45359;
	int unsigned r;

	// -1 in an expected field means take it from the model
	step_t steps [24] = '{
		'{SEND, 1, 2, 0, 0}, '{SEND, 1, 0, 0, 0}, '{SEND, 1, 3, 0, 0},
		'{CREDIT, 0, 0, 1, 2}, '{CREDIT, 0, 0, 1, 0}, '{CREDIT, 0, 0, 1, 3},
		// seven into queue 2 without credit push out the oldest
		'{FILL, 2, 7, 0, 0}, '{DRAIN, 0, 0, 0, 0},
		'{THR, 0, 3, 0, 0},
		'{SEND, 0, 1, 0, 0}, '{SEND, 0, 2, 0, 0}, '{SEND, 3, 3, 0, 0}, '{SEND, 3, 0, 0, 0},
		'{CREDIT, 0, 0, 0, 1}, '{DRAIN, 0, 0, 0, 0},
		'{FILL, 0, 5, 0, 0}, '{FILL, 3, 5, 0, 0}, '{CREDIT, 0, 0, 3, -1}, '{DRAIN, 0, 0, 0, 0},
		'{THR, 0, 5, 0, 0},
		'{FILL, 0, 5, 0, 0}, '{FILL, 3, 5, 0, 0}, '{CREDIT, 0, 0, 0, -1}, '{DRAIN, 0, 0, 0, 0}
	};

	qos_buffer_top u_qos_buffer_top (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic int unsigned next_rand();
		seed = seed * 32'd1103515245 + 32'd12345;
		return (seed >> 16) & 32'h7fff;
	endfunction

	task automatic compare_value(string what, int got, int exp);
		if (got != exp) begin
			errors++;
			$display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic remove_head(int q);
		for (int i = 0; i < `QOS_DEPTH - 1; i++) begin
			mq[q][i] = mq[q][i+1];
		end
		mocc[q]--;
	endtask

	task automatic store_packet(int q, int d);
		if (mocc[q] == `QOS_DEPTH) begin
			drop_cnt[q]++;
			remove_head(q);
		end
		mq[q][mocc[q]] = d;
		mocc[q]++;
		rx_cnt[q]++;
	endtask

	// fullest queue with the highest index winning a tie above the threshold
	function automatic int pick_queue();
		int mx;
		int sel;
		mx = 0;
		sel = -1;
		for (int q = 0; q < `QOS_NUM_Q; q++) begin
			if (mocc[q] > mx) mx = mocc[q];
		end
		for (int q = 0; q < `QOS_NUM_Q; q++) begin
			if (mx > 0 && mocc[q] == mx && (sel < 0 || mx > thr)) sel = q;
		end
		return sel;
	endfunction

	task automatic send_packet(int q, int d);
		logic [3:0] bits;
		bits = {q[1:0], d[1:0]};
		for (int i = 3; i >= 0; i--) begin
			bit_valid_i = 1'b1;
			bit_i = bits[i];
			@(negedge clk);
			compare_value("rd_valid_o without credit", rd_valid_o, 0);
		end
		bit_valid_i = 1'b0;
		@(negedge clk);
		store_packet(q, d);
	endtask

	task automatic fill_queue(int q, int n);
		for (int i = 0; i < n; i++) begin
			send_packet(q, next_rand() % 4);
		end
	endtask

	task automatic give_credit(int exp_q, int exp_d);
		int sel;
		int want_q;
		int want_d;
		int n;
		sel = pick_queue();
		want_q = (exp_q < 0) ? sel : exp_q;
		want_d = (exp_d < 0) ? mq[sel][0] : exp_d;
		remove_head(sel);
		rd_cnt[sel]++;
		rd_credit_i = 1'b1;
		@(negedge clk);
		rd_credit_i = 1'b0;
		n = 0;
		while (!rd_valid_o && n < 8) begin
			@(negedge clk);
			n++;
		end
		if (!rd_valid_o) begin
			timeouts++;
			$display("Timeout: no read came out within %0d cycles of a credit at %0t", n, $time);
		end else begin
			compare_value("rd_qid_o", rd_qid_o, want_q);
			compare_value("rd_data_o", rd_data_o, want_d);
		end
		@(negedge clk);
		// one credit gives exactly one read
		compare_value("rd_valid_o after a single read", rd_valid_o, 0);
	endtask

	task automatic drain_all();
		while (pick_queue() >= 0) begin
			give_credit(-1, -1);
		end
	endtask

	task automatic set_threshold(int t);
		cfg_we_i = 1'b1;
		cfg_thr_i = t[2:0];
		@(negedge clk);
		cfg_we_i = 1'b0;
		thr = t;
	endtask

	task automatic check_stats();
		for (int q = 0; q < `QOS_NUM_Q; q++) begin
			stat_qid_i = 2'(q);
			@(negedge clk);
			compare_value($sformatf("rx_count_o q%0d", q), rx_count_o, rx_cnt[q] % 128);
			compare_value($sformatf("rd_count_o q%0d", q), rd_count_o, rd_cnt[q] % 128);
			compare_value($sformatf("drop_count_o q%0d", q), drop_count_o, drop_cnt[q] % 128);
		end
	endtask

	initial begin
		arst_n_i = 1'b0;
		bit_valid_i = 1'b0;
		bit_i = 1'b0;
		rd_credit_i = 1'b0;
		cfg_we_i = 1'b0;
		cfg_thr_i = 3'd0;
		stat_qid_i = 2'd0;
		for (int q = 0; q < `QOS_NUM_Q; q++) begin
			mocc[q] = 0;
			rx_cnt[q] = 0;
			rd_cnt[q] = 0;
			drop_cnt[q] = 0;
		end
		repeat (3) @(negedge clk);
		arst_n_i = 1'b1;
		@(negedge clk);
		foreach (steps[i]) begin
			case (steps[i].op)
				SEND:    send_packet(steps[i].q, steps[i].val);
				CREDIT:  give_credit(steps[i].exp_q, steps[i].exp_d);
				THR:     set_threshold(steps[i].val);
				FILL:    fill_queue(steps[i].q, steps[i].val);
				default: drain_all();
			endcase
		end
		check_stats();
		// random mix of packets and credits
		for (int i = 0; i < 80; i++) begin
			r = next_rand();
			if (r % 4 == 0 && pick_queue() >= 0) begin
				give_credit(-1, -1);
			end else begin
				send_packet((r >> 2) % 4, (r >> 4) % 4);
			end
		end
		drain_all();
		check_stats();
		$display("checks done: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: verilog/pkt_assembler.sv
module pkt_assembler (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   bit_valid_i,
	input  logic                   bit_i,
	output logic                   pkt_valid_o,
	output qos_pkt_pkg::qid_t      pkt_qid_o,
	output qos_pkt_pkg::payload_t  pkt_data_o
);
	import qos_pkt_pkg::*;

	asm_state_t state;
	logic [1:0] bit_cnt;
	logic [3:0] shreg;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state   <= COLLECT;
			bit_cnt <= 2'd0;
		end else begin
			if (bit_valid_i) begin
				bit_cnt <= bit_cnt + 2'd1;
			end
			case (state)
				COLLECT: begin
					if (bit_valid_i && bit_cnt == 2'd3) begin
						state <= EMIT;
					end
				end
				EMIT: begin
					// a new packet may already be starting here
					state <= COLLECT;
				end
				default: begin
					state <= COLLECT;
				end
			endcase
		end
	end

	// first bit lands in shreg[3]
	always_ff @(posedge clk) begin
		if (bit_valid_i) begin
			shreg <= {shreg[2:0], bit_i};
		end
	end

	assign pkt_valid_o = (state == EMIT);
	assign pkt_qid_o   = shreg[3:2];
	assign pkt_data_o  = shreg[1:0];

endmodule

// File: verilog/qos_buffer_top.sv
`include "qos_config.svh"

module qos_buffer_top (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     bit_valid_i,
	input  logic                     bit_i,
	input  logic                     rd_credit_i,
	input  logic                     cfg_we_i,
	input  qos_pkt_pkg::occ_t        cfg_thr_i,
	input  qos_pkt_pkg::qid_t        stat_qid_i,
	output logic                     rd_valid_o,
	output qos_pkt_pkg::qid_t        rd_qid_o,
	output qos_pkt_pkg::payload_t    rd_data_o,
	output qos_stat_pkg::stat_cnt_t  rx_count_o,
	output qos_stat_pkg::stat_cnt_t  rd_count_o,
	output qos_stat_pkg::stat_cnt_t  drop_count_o
);
	import qos_pkt_pkg::*;

	logic                  pkt_valid;
	qid_t                  pkt_qid;
	payload_t              pkt_data;
	logic [`QOS_NUM_Q-1:0] drop;
	occ_t                  thr;

	qos_if u_qif ();

	pkt_assembler u_pkt_assembler (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.bit_valid_i (bit_valid_i),
		.bit_i       (bit_i),
		.pkt_valid_o (pkt_valid),
		.pkt_qid_o   (pkt_qid),
		.pkt_data_o  (pkt_data)
	);

	queue_bank u_queue_bank (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.pkt_valid_i (pkt_valid),
		.pkt_qid_i   (pkt_qid),
		.pkt_data_i  (pkt_data),
		.qbus        (u_qif.bank),
		.drop_o      (drop)
	);

	sched_cfg_regs u_sched_cfg_regs (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.cfg_we_i  (cfg_we_i),
		.cfg_thr_i (cfg_thr_i),
		.thr_o     (thr)
	);

	read_scheduler u_read_scheduler (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.rd_credit_i (rd_credit_i),
		.thr_i       (thr),
		.qbus        (u_qif.sched),
		.rd_valid_o  (rd_valid_o),
		.rd_qid_o    (rd_qid_o),
		.rd_data_o   (rd_data_o)
	);

	stat_counters u_stat_counters (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.pkt_valid_i  (pkt_valid),
		.pkt_qid_i    (pkt_qid),
		.drop_i       (drop),
		.rd_valid_i   (rd_valid_o),
		.rd_qid_i     (rd_qid_o),
		.stat_qid_i   (stat_qid_i),
		.rx_count_o   (rx_count_o),
		.rd_count_o   (rd_count_o),
		.drop_count_o (drop_count_o)
	);

endmodule

// File: verilog/qos_config.svh
`ifndef QOS_CONFIG_SVH
`define QOS_CONFIG_SVH

// queue count, fixed by the 2-bit queue field
`define QOS_NUM_Q 4

// entries per queue
`define QOS_DEPTH 6

// statistic counters wrap at this width
`define QOS_CNT_W 7

// enough for seven outstanding credits
`define QOS_CRED_W 3

// tie-break threshold after reset
`define QOS_THR_RST 3

`endif

// File: verilog/qos_if.sv
`include "qos_config.svh"

interface qos_if;
	import qos_pkt_pkg::*;

	// per-queue state from the bank
	occ_t     occ  [`QOS_NUM_Q];
	payload_t head [`QOS_NUM_Q];

	// pop request, only for a nonempty queue
	logic pop;
	qid_t pop_qid;

	modport bank (
		output occ,
		output head,
		input  pop,
		input  pop_qid
	);

	modport sched (
		input  occ,
		input  head,
		output pop,
		output pop_qid
	);

endinterface

// File: verilog/qos_pkt_pkg.sv
`include "qos_config.svh"

package qos_pkt_pkg;

	// queue number field of a packet
	typedef logic [$clog2(`QOS_NUM_Q)-1:0] qid_t;

	// payload field of a packet
	typedef logic [1:0] payload_t;

	// 0 to QOS_DEPTH entries
	typedef logic [$clog2(`QOS_DEPTH+1)-1:0] occ_t;

	// bit collection, then one cycle of packet output
	typedef enum logic {
		COLLECT,
		EMIT
	} asm_state_t;

endpackage

// File: verilog/qos_stat_pkg.sv
`include "qos_config.svh"

package qos_stat_pkg;

	// one wrapping statistic counter
	typedef logic [`QOS_CNT_W-1:0] stat_cnt_t;

endpackage

// File: verilog/queue_bank.sv
`include "qos_config.svh"

module queue_bank (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   pkt_valid_i,
	input  qos_pkt_pkg::qid_t      pkt_qid_i,
	input  qos_pkt_pkg::payload_t  pkt_data_i,
	qos_if.bank                    qbus,
	output logic [`QOS_NUM_Q-1:0]  drop_o
);
	import qos_pkt_pkg::*;

	// entry 0 is the oldest
	payload_t mem [`QOS_NUM_Q][`QOS_DEPTH];
	occ_t     occ [`QOS_NUM_Q];
	occ_t     wr_idx [`QOS_NUM_Q];

	logic [`QOS_NUM_Q-1:0] push;
	logic [`QOS_NUM_Q-1:0] pop;
	logic [`QOS_NUM_Q-1:0] full;
	logic [`QOS_NUM_Q-1:0] shift;

	always_comb begin
		for (int q = 0; q < `QOS_NUM_Q; q++) begin
			push[q]   = pkt_valid_i && (pkt_qid_i == qid_t'(q));
			pop[q]    = qbus.pop && (qbus.pop_qid == qid_t'(q));
			full[q]   = (occ[q] == occ_t'(`QOS_DEPTH));
			shift[q]  = pop[q] || (push[q] && full[q]);
			drop_o[q] = push[q] && full[q] && !pop[q];
			// write behind the last entry after any shift
			wr_idx[q] = shift[q] ? occ[q] - occ_t'(1) : occ[q];
			qbus.occ[q]  = occ[q];
			qbus.head[q] = mem[q][0];
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int q = 0; q < `QOS_NUM_Q; q++) begin
				occ[q] <= '0;
			end
		end else begin
			for (int q = 0; q < `QOS_NUM_Q; q++) begin
				if (push[q] && !pop[q] && !full[q]) begin
					occ[q] <= occ[q] + occ_t'(1);
				end else if (pop[q] && !push[q]) begin
					occ[q] <= occ[q] - occ_t'(1);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int q = 0; q < `QOS_NUM_Q; q++) begin
			if (shift[q]) begin
				for (int i = 0; i < `QOS_DEPTH - 1; i++) begin
					mem[q][i] <= mem[q][i+1];
				end
			end
			if (push[q]) begin
				mem[q][wr_idx[q]] <= pkt_data_i;
			end
		end
	end

endmodule

// File: verilog/read_scheduler.sv
`include "qos_config.svh"

module read_scheduler (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   rd_credit_i,
	input  qos_pkt_pkg::occ_t      thr_i,
	qos_if.sched                   qbus,
	output logic                   rd_valid_o,
	output qos_pkt_pkg::qid_t      rd_qid_o,
	output qos_pkt_pkg::payload_t  rd_data_o
);
	import qos_pkt_pkg::*;

	logic [`QOS_CRED_W-1:0] cred;
	occ_t max_occ;
	qid_t sel;
	logic can_read;

	always_comb begin
		max_occ = '0;
		sel     = '0;
		for (int q = 0; q < `QOS_NUM_Q; q++) begin
			if (qbus.occ[q] > max_occ) begin
				max_occ = qbus.occ[q];
			end
		end
		// above threshold the highest queue wins a tie, else the lowest
		if (max_occ > thr_i) begin
			for (int q = 0; q < `QOS_NUM_Q; q++) begin
				if (qbus.occ[q] == max_occ) begin
					sel = qid_t'(q);
				end
			end
		end else begin
			for (int q = `QOS_NUM_Q - 1; q >= 0; q--) begin
				if (qbus.occ[q] == max_occ) begin
					sel = qid_t'(q);
				end
			end
		end
		can_read = (cred != '0) && (max_occ != '0);
	end

	assign qbus.pop     = can_read;
	assign qbus.pop_qid = sel;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			cred       <= '0;
			rd_valid_o <= 1'b0;
		end else begin
			// returned credit and consumed credit cancel out
			if (rd_credit_i && !can_read) begin
				cred <= cred + 1'b1;
			end else if (can_read && !rd_credit_i) begin
				cred <= cred - 1'b1;
			end
			rd_valid_o <= can_read;
		end
	end

	always_ff @(posedge clk) begin
		if (can_read) begin
			rd_qid_o  <= sel;
			rd_data_o <= qbus.head[sel];
		end
	end

endmodule

// File: verilog/sched_cfg_regs.sv
`include "qos_config.svh"

module sched_cfg_regs (
	input  logic               clk,
	input  logic               arst_n_i,
	input  logic               cfg_we_i,
	input  qos_pkt_pkg::occ_t  cfg_thr_i,
	output qos_pkt_pkg::occ_t  thr_o
);
	import qos_pkt_pkg::*;

	occ_t thr_q;

	// tie policy may be changed while traffic runs
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			thr_q <= occ_t'(`QOS_THR_RST);
		end else if (cfg_we_i) begin
			thr_q <= cfg_thr_i;
		end
	end

	assign thr_o = thr_q;

endmodule

// File: verilog/stat_counters.sv
`include "qos_config.svh"

module stat_counters (
	input  logic                     clk,
	input  logic                     arst_n_i,
	input  logic                     pkt_valid_i,
	input  qos_pkt_pkg::qid_t        pkt_qid_i,
	input  logic [`QOS_NUM_Q-1:0]    drop_i,
	input  logic                     rd_valid_i,
	input  qos_pkt_pkg::qid_t        rd_qid_i,
	input  qos_pkt_pkg::qid_t        stat_qid_i,
	output qos_stat_pkg::stat_cnt_t  rx_count_o,
	output qos_stat_pkg::stat_cnt_t  rd_count_o,
	output qos_stat_pkg::stat_cnt_t  drop_count_o
);
	import qos_pkt_pkg::*;
	import qos_stat_pkg::*;

	stat_cnt_t rx_cnt   [`QOS_NUM_Q];
	stat_cnt_t rd_cnt   [`QOS_NUM_Q];
	stat_cnt_t drop_cnt [`QOS_NUM_Q];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int q = 0; q < `QOS_NUM_Q; q++) begin
				rx_cnt[q]   <= '0;
				rd_cnt[q]   <= '0;
				drop_cnt[q] <= '0;
			end
		end else begin
			for (int q = 0; q < `QOS_NUM_Q; q++) begin
				if (pkt_valid_i && pkt_qid_i == qid_t'(q)) begin
					rx_cnt[q] <= rx_cnt[q] + 1'b1;
				end
				if (rd_valid_i && rd_qid_i == qid_t'(q)) begin
					rd_cnt[q] <= rd_cnt[q] + 1'b1;
				end
				if (drop_i[q]) begin
					drop_cnt[q] <= drop_cnt[q] + 1'b1;
				end
			end
		end
	end

	assign rx_count_o   = rx_cnt[stat_qid_i];
	assign rd_count_o   = rd_cnt[stat_qid_i];
	assign drop_count_o = drop_cnt[stat_qid_i];

endmodule
